// ==== compile.f ====
+incdir+include
design/sd_link_pkg.sv
design/sd_cmd_decode.sv
design/sd_card_exec.sv
design/sd_resp_format.sv
design/sd_link_top.sv
testbench/sd_link_chk.sv
testbench/sd_link_tb.sv

// ==== Bender.yml ====
package:
  name: sd_link

sources:
  - include_dirs:
      - include
    files:
      - design/sd_link_pkg.sv
      - design/sd_cmd_decode.sv
      - design/sd_card_exec.sv
      - design/sd_resp_format.sv
      - design/sd_link_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - testbench/sd_link_chk.sv
      - testbench/sd_link_tb.sv

// ==== testbench/sd_link_tb.sv ====
// Tests run in order and share card state, so each expects the state left by the one before.
`default_nettype none
`include "sd_link_params.svh"

module sd_link_tb;
   import sd_link_pkg::*;

   localparam int   CLK_HALF     = 50;
   localparam int   CLK_PERIOD   = 2 * CLK_HALF;
   localparam int   DRIVE_DLY    = 10;
   localparam int   RESP_TIMEOUT = 8;
   localparam int   STALL_CLOCKS = 20;
   localparam int   CMD_COUNT    = 20;
   localparam int   CMD_CLOCKS   = 16;
   localparam int   WATCHDOG_CLOCKS = 2 * (3 + CMD_COUNT * CMD_CLOCKS + STALL_CLOCKS);
   localparam rca_t CARD_RCA     = `SD_RCA_STEP;
   localparam logic [127:0] CARD_CID = `SD_CID;

   logic        clk_50;
   logic        reset_s;
   logic [47:0] cmd_in;
   logic        cmd_crc_good;
   logic        cmd_act;
   logic        resp_done;
   resp_frame_t resp_out;
   resp_kind_e  resp_type;
   logic        resp_act;
   card_state_e card_state;
   cmd_index_t  cmd_last;
   logic        err_cmd_crc;
   logic        err_unhandled_cmd;
   logic        info_card_desel;
   int          error_count;
   int          test_count;

   sd_link_top dut (
      .clk_50            (clk_50),
      .reset_s           (reset_s),
      .cmd_in            (cmd_in),
      .cmd_crc_good      (cmd_crc_good),
      .cmd_act           (cmd_act),
      .resp_done         (resp_done),
      .resp_out          (resp_out),
      .resp_type         (resp_type),
      .resp_act          (resp_act),
      .card_state        (card_state),
      .cmd_last          (cmd_last),
      .err_cmd_crc       (err_cmd_crc),
      .err_unhandled_cmd (err_unhandled_cmd),
      .info_card_desel   (info_card_desel)
   );

   bind sd_resp_format sd_link_chk chk (.*);

   initial begin
      clk_50 = 1'b0;
      forever #CLK_HALF clk_50 = ~clk_50;
   end

   initial begin
      #(WATCHDOG_CLOCKS * CLK_PERIOD);
      $display("watchdog expired at %0t, a test never finished", $time);
      $display("TEST RESULT: FAIL");
      $finish;
   end

   // start 01, index, argument, crc7 left at zero, end bit
   function automatic logic [47:0] cmd_frame(input cmd_index_t idx, input cmd_arg_t arg);
      return {2'b01, idx, arg, 7'h00, 1'b1};
   endfunction

   // 48-bit response left aligned in the 136-bit frame
   function automatic resp_frame_t short_frame(input cmd_index_t idx, input logic [31:0] body,
                                               input logic [7:0] tail);
      return {2'b00, idx, body, tail, 88'h0};
   endfunction

   // ready_for_data, the state field and the app flag, no error bits
   function automatic card_status_t status_word(input card_state_e st, input logic app);
      card_status_t s;
      s = '0;
      s[`SD_STAT_READY_FOR_DATA] = 1'b1;
      s[`SD_STAT_STATE_LSB +: 4] = st;
      s[`SD_STAT_APP_CMD] = app;
      return s;
   endfunction

   task automatic report_fail(input string msg);
      $display("%s", msg);
      error_count++;
   endtask

   task automatic check_frame(input string name, input resp_frame_t got, input resp_frame_t exp);
      if (got !== exp) begin
         $display("ERROR %s got %h expected %h", name, got, exp);
         error_count++;
      end
   endtask

   task automatic check_kind(input string name, input resp_kind_e got, input resp_kind_e exp);
      if (got !== exp) begin
         $display("ERROR %s got %h expected %h", name, got, exp);
         error_count++;
      end
   endtask

   task automatic check_state(input string name, input card_state_e got, input card_state_e exp);
      if (got !== exp) begin
         $display("ERROR %s got %h expected %h", name, got, exp);
         error_count++;
      end
   endtask

   task automatic check_index(input string name, input cmd_index_t got, input cmd_index_t exp);
      if (got !== exp) begin
         $display("ERROR %s got %h expected %h", name, got, exp);
         error_count++;
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("ERROR %s got %h expected %h", name, got, exp);
         error_count++;
      end
   endtask

   task automatic end_test(input string name, input int start);
      test_count++;
      if (error_count == start) begin
         $display("test %0d %s: passed", test_count, name);
      end else begin
         $display("test %0d %s: %0d errors", test_count, name, error_count - start);
      end
   endtask

   // called just after an edge, accepted on the next one
   task automatic send_cmd(input cmd_index_t idx, input cmd_arg_t arg, input logic crc_ok);
      cmd_in       = cmd_frame(idx, arg);
      cmd_crc_good = crc_ok;
      cmd_act      = 1'b1;
      @(posedge clk_50);
      #DRIVE_DLY;
      cmd_act = 1'b0;
   endtask

   task automatic wait_resp(output int clocks, output logic seen);
      clocks = 0;
      seen   = 1'b0;
      while (!seen && clocks < RESP_TIMEOUT) begin
         @(posedge clk_50);
         #DRIVE_DLY;
         clocks++;
         seen = resp_act;
      end
   endtask

   // ends one clock after sent, when card_state has been committed
   task automatic finish_resp(input int hold);
      repeat (hold) begin
         @(posedge clk_50);
         #DRIVE_DLY;
      end
      resp_done = 1'b1;
      @(posedge clk_50);
      #DRIVE_DLY;
      resp_done = 1'b0;
      @(posedge clk_50);
      #DRIVE_DLY;
   endtask

   task automatic expect_resp(input string name, input cmd_index_t idx, input cmd_arg_t arg,
                              input resp_kind_e kind, input resp_frame_t frame,
                              input card_state_e state_after, output int lat);
      logic seen;
      send_cmd(idx, arg, 1'b1);
      wait_resp(lat, seen);
      if (!seen) begin
         report_fail($sformatf("no response to %s", name));
      end else begin
         check_kind({name, " resp_type"}, resp_type, kind);
         check_frame({name, " resp_out"}, resp_out, frame);
         finish_resp(2);
         check_state({name, " card_state"}, card_state, state_after);
      end
   endtask

   task automatic expect_silence(input string name, input cmd_index_t idx, input cmd_arg_t arg,
                                 input logic crc_ok);
      int   clocks;
      logic seen;
      send_cmd(idx, arg, crc_ok);
      wait_resp(clocks, seen);
      if (seen) begin
         report_fail($sformatf("%s raised resp_act but should get no response", name));
         finish_resp(0);
      end
   endtask

   task automatic test_reset_cmd0();
      int start;
      start = error_count;
      check_state("card_state after reset", card_state, CARD_IDLE);
      check_flag("resp_act after reset", resp_act, 1'b0);
      check_flag("err_cmd_crc after reset", err_cmd_crc, 1'b0);
      check_flag("err_unhandled_cmd after reset", err_unhandled_cmd, 1'b0);
      check_flag("info_card_desel after reset", info_card_desel, 1'b0);
      expect_silence("cmd0", `SD_CMD0_GO_IDLE, 32'h0, 1'b1);
      check_state("card_state after cmd0", card_state, CARD_IDLE);
      end_test("reset and cmd0", start);
   endtask

   task automatic test_init();
      int           start;
      int           lat;
      card_status_t st;
      logic [31:0]  ocr_up;
      start  = error_count;
      // ccs set for a high capacity card
      ocr_up = 32'h4000_0000 | `SD_VOLTAGE_WINDOW | (32'd1 << `SD_OCR_POWERED_UP);
      expect_resp("cmd8", `SD_CMD8_SEND_IF_COND, 32'h1AA, RESP_R7,
                  short_frame(`SD_CMD8_SEND_IF_COND, 32'h1AA, 8'h01), CARD_IDLE, lat);
      if (lat != 3) begin
         report_fail($sformatf("resp_act rose %0d clocks after acceptance, not 3", lat));
      end
      expect_resp("cmd55", `SD_CMD55_APP_CMD, 32'h0, RESP_R1,
                  short_frame(`SD_CMD55_APP_CMD, status_word(CARD_IDLE, 1'b1), 8'h01),
                  CARD_IDLE, lat);
      expect_resp("acmd41", `SD_ACMD41_SEND_OP_COND, 32'h40FF_8000, RESP_R3,
                  short_frame(6'b111111, ocr_up, 8'hFF), CARD_READY, lat);
      expect_resp("cmd2", `SD_CMD2_ALL_SEND_CID, 32'h0, RESP_R2,
                  {2'b00, 6'b111111, CARD_CID[127:1], 1'b1}, CARD_IDENT, lat);
      st = status_word(CARD_IDENT, 1'b0);
      expect_resp("cmd3", `SD_CMD3_SEND_REL_ADDR, 32'h0, RESP_R6,
                  short_frame(`SD_CMD3_SEND_REL_ADDR, {CARD_RCA, 3'b000, st[12:0]}, 8'h01),
                  CARD_STBY, lat);
      end_test("initialisation", start);
   endtask

   task automatic test_select_status();
      int start;
      int lat;
      start = error_count;
      expect_resp("cmd7 select", `SD_CMD7_SEL_CARD, {CARD_RCA, 16'h0}, RESP_R1B,
                  short_frame(`SD_CMD7_SEL_CARD, status_word(CARD_STBY, 1'b0), 8'h01),
                  CARD_TRAN, lat);
      expect_resp("cmd13", `SD_CMD13_SEND_STATUS, {CARD_RCA, 16'h0}, RESP_R1,
                  short_frame(`SD_CMD13_SEND_STATUS, status_word(CARD_TRAN, 1'b0), 8'h01),
                  CARD_TRAN, lat);
      // status bits 12..9 inside the frame
      check_state("cmd13 state field", card_state_e'(resp_out[108:105]), CARD_TRAN);
      expect_silence("cmd7 deselect", `SD_CMD7_SEL_CARD, 32'hBEEF_0000, 1'b1);
      check_flag("info_card_desel", info_card_desel, 1'b1);
      check_state("card_state after deselect", card_state, CARD_STBY);
      end_test("select and status", start);
   endtask

   task automatic test_errors();
      int start;
      start = error_count;
      expect_silence("bad crc frame", `SD_CMD13_SEND_STATUS, {CARD_RCA, 16'h0}, 1'b0);
      check_flag("err_cmd_crc", err_cmd_crc, 1'b1);
      expect_silence("cmd20", 6'd20, 32'h0, 1'b1);
      check_flag("err_unhandled_cmd", err_unhandled_cmd, 1'b1);
      expect_silence("cmd2 in stby", `SD_CMD2_ALL_SEND_CID, 32'h0, 1'b1);
      check_state("card_state after cmd2 in stby", card_state, CARD_STBY);
      end_test("errors", start);
   endtask

   task automatic test_backpressure();
      int   start;
      int   clocks;
      int   i;
      logic seen;
      start = error_count;
      send_cmd(`SD_CMD13_SEND_STATUS, {CARD_RCA, 16'h0}, 1'b1);
      wait_resp(clocks, seen);
      if (!seen) begin
         report_fail("no response to cmd13 under back-pressure");
      end else begin
         for (i = 0; i < STALL_CLOCKS; i++) begin
            // a second edge while busy must be dropped
            if (i == 4) begin
               cmd_in  = cmd_frame(`SD_CMD55_APP_CMD, {CARD_RCA, 16'h0});
               cmd_act = 1'b1;
            end
            if (i == 6) begin
               cmd_act = 1'b0;
            end
            @(posedge clk_50);
            #DRIVE_DLY;
            check_flag("resp_act while stalled", resp_act, 1'b1);
         end
         check_index("cmd_last", cmd_last, `SD_CMD13_SEND_STATUS);
         check_kind("stalled resp_type", resp_type, RESP_R1);
         check_frame("stalled resp_out", resp_out,
                     short_frame(`SD_CMD13_SEND_STATUS, status_word(CARD_STBY, 1'b0), 8'h01));
         finish_resp(0);
         wait_resp(clocks, seen);
         if (seen) begin
            report_fail("the command sent during the stall produced a second response");
            finish_resp(0);
         end
      end
      end_test("back-pressure", start);
   endtask

   task automatic test_inactive();
      int start;
      start = error_count;
      expect_silence("cmd15", `SD_CMD15_GO_INACTIVE, {CARD_RCA, 16'h0}, 1'b1);
      check_state("card_state after cmd15", card_state, CARD_INA);
      expect_silence("cmd0 in ina", `SD_CMD0_GO_IDLE, 32'h0, 1'b1);
      check_state("card_state after cmd0 in ina", card_state, CARD_INA);
      end_test("inactive", start);
   endtask

   initial begin
      reset_s      = 1'b0;
      cmd_in       = '0;
      cmd_crc_good = 1'b1;
      cmd_act      = 1'b0;
      resp_done    = 1'b0;
      error_count  = 0;
      test_count   = 0;
      repeat (3) begin
         @(posedge clk_50);
      end
      #DRIVE_DLY;
      reset_s = 1'b1;

      test_reset_cmd0();
      test_init();
      test_select_status();
      test_errors();
      test_backpressure();
      test_inactive();

      $display("tests %0d errors %0d", test_count, error_count);
      if (error_count == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== testbench/sd_link_chk.sv ====
// Bound into sd_resp_format. Nothing is checked while reset_s is low.
`default_nettype none

module sd_link_chk (
   input wire                           clk_50,
   input wire                           reset_s,
   input wire                           resp_act,
   input wire                           resp_done,
   input wire                           sent,
   input wire sd_link_pkg::resp_kind_e  resp_type
);

   // the phy owns the frame until it reports done
   act_held: assert property (@(posedge clk_50) disable iff (!reset_s)
      (resp_act && !resp_done) |=> resp_act)
      else $error("resp_act dropped before resp_done");

   sent_single: assert property (@(posedge clk_50) disable iff (!reset_s)
      sent |=> !sent)
      else $error("sent held for more than one clock");

   // type must not move under the phy
   type_stable: assert property (@(posedge clk_50) disable iff (!reset_s)
      resp_act |=> (!resp_act || $stable(resp_type)))
      else $error("resp_type changed while resp_act was high");

endmodule

`default_nettype wire

// ==== design/sd_link_top.sv ====
// Inputs must be synchronous to clk_50. Command and response only, with no data transfer path.
`default_nettype none

module sd_link_top (
   input  wire                        clk_50,
   input  wire                        reset_s,
   input  wire [47:0]                 cmd_in,
   input  wire                        cmd_crc_good,
   input  wire                        cmd_act,
   input  wire                        resp_done,
   output sd_link_pkg::resp_frame_t   resp_out,
   output sd_link_pkg::resp_kind_e    resp_type,
   output logic                       resp_act,
   output sd_link_pkg::card_state_e   card_state,
   output sd_link_pkg::cmd_index_t    cmd_last,
   output logic                       err_cmd_crc,
   output logic                       err_unhandled_cmd,
   output logic                       info_card_desel
);
   import sd_link_pkg::*;

   cmd_op_t   op;
   resp_req_t req;
   logic      op_valid;
   logic      crc_fail;
   logic      busy;
   logic      app_pending;
   logic      req_valid;
   logic      sent;

   // port names match the local nets one to one
   sd_cmd_decode u_decode (.*);

   sd_card_exec u_exec (.*);

   sd_resp_format u_format (.*);

endmodule

`default_nettype wire

// ==== design/sd_resp_format.sv ====
// resp_done is sampled as a level, so the phy must drop it before the next response is due.
`default_nettype none
`include "sd_link_params.svh"

module sd_resp_format (
   input  wire                          clk_50,
   input  wire                          reset_s,
   input  wire                          req_valid,
   input  wire sd_link_pkg::resp_req_t  req,
   input  wire                          resp_done,
   output sd_link_pkg::resp_frame_t     resp_out,
   output sd_link_pkg::resp_kind_e      resp_type,
   output logic                         resp_act,
   output logic                         sent
);
   import sd_link_pkg::*;

   localparam logic [127:0] CARD_CID = `SD_CID;

   typedef enum logic [1:0] {
      FMT_IDLE,
      FMT_LOAD,
      FMT_ACT
   } fmt_state_e;

   fmt_state_e  fmt_state;
   resp_frame_t frame;

   // start and direction bits lead, crc and end bit are left to the phy
   always_comb begin
      case (req.kind)
         RESP_R1, RESP_R1B: frame = {2'b00, req.index, req.status, 8'h01, 88'h0};
         RESP_R2:           frame = {2'b00, 6'b111111, CARD_CID[127:1], 1'b1};
         RESP_R3:           frame = {2'b00, 6'b111111, req.payload, 8'hFF, 88'h0};
         RESP_R6:           frame = {2'b00, `SD_CMD3_SEND_REL_ADDR, req.payload, 8'h01, 88'h0};
         RESP_R7:           frame = {2'b00, `SD_CMD8_SEND_IF_COND, req.payload, 8'h01, 88'h0};
         default:           frame = '0;
      endcase
   end

   always_ff @(posedge clk_50) begin
      if (!reset_s) begin
         fmt_state <= FMT_IDLE;
         resp_act  <= 1'b0;
         sent      <= 1'b0;
      end else begin
         sent <= 1'b0;
         case (fmt_state)
            FMT_IDLE: begin
               if (req_valid) begin
                  fmt_state <= FMT_LOAD;
               end
            end
            FMT_LOAD: begin
               resp_act  <= 1'b1;
               fmt_state <= FMT_ACT;
            end
            FMT_ACT: begin
               // hold until the phy has shifted the frame out
               if (resp_done) begin
                  resp_act  <= 1'b0;
                  sent      <= 1'b1;
                  fmt_state <= FMT_IDLE;
               end
            end
            default: fmt_state <= FMT_IDLE;
         endcase
      end
   end

   // frame and type stay put for the whole handshake
   always_ff @(posedge clk_50) begin
      if (req_valid && fmt_state == FMT_IDLE) begin
         resp_out  <= frame;
         resp_type <= req.kind;
      end
   end

endmodule

`default_nettype wire

// ==== design/sd_card_exec.sv ====
// SD bus mode only. The data, rcv, prg and dis states are never entered since data transfer is absent.
`default_nettype none
`include "sd_link_params.svh"

module sd_card_exec (
   input  wire                         clk_50,
   input  wire                         reset_s,
   input  wire                         op_valid,
   input  wire sd_link_pkg::cmd_op_t   op,
   input  wire                         crc_fail,
   input  wire                         sent,
   output logic                        busy,
   output logic                        app_pending,
   output logic                        req_valid,
   output sd_link_pkg::resp_req_t      req,
   output sd_link_pkg::card_state_e    card_state,
   output logic                        err_cmd_crc,
   output logic                        err_unhandled_cmd,
   output logic                        info_card_desel
);
   import sd_link_pkg::*;

   localparam card_status_t STATUS_RESET = 32'd1 << `SD_STAT_READY_FOR_DATA;
   // high capacity, not yet powered up
   localparam ocr_t OCR_RESET = {8'h40, `SD_VOLTAGE_WINDOW};

   card_state_e   state_next;
   card_state_e   state_dec;
   rca_t          rca;
   rca_t          rca_dec;
   ocr_t          ocr;
   ocr_t          ocr_dec;
   card_status_t  status;
   card_status_t  status_dec;
   resp_kind_e    kind_dec;
   resp_payload_t payload_dec;
   logic          rca_match;
   logic          app_dec;
   logic          unhandled_dec;
   logic          desel_dec;
   logic          reset_dec;
   logic          last_app;

   assign rca_match = (op.arg[31:16] == rca);

   always_comb begin
      state_dec     = card_state;
      rca_dec       = rca;
      ocr_dec       = ocr;
      app_dec       = op.app;
      kind_dec      = RESP_BAD;
      unhandled_dec = 1'b0;
      desel_dec     = 1'b0;
      reset_dec     = 1'b0;
      if (op.app) begin
         if (card_state == CARD_IDLE) begin
            kind_dec = RESP_R3;
            ocr_dec[`SD_OCR_POWERED_UP] = 1'b1;
            state_dec = CARD_READY;
         end
      end else begin
         case (op.index)
            `SD_CMD0_GO_IDLE: begin
               if (card_state != CARD_INA) begin
                  reset_dec = 1'b1;
                  kind_dec  = RESP_NONE;
               end
            end
            `SD_CMD2_ALL_SEND_CID: begin
               if (card_state == CARD_READY) begin
                  kind_dec  = RESP_R2;
                  state_dec = CARD_IDENT;
               end
            end
            `SD_CMD3_SEND_REL_ADDR: begin
               if (card_state == CARD_IDENT || card_state == CARD_STBY) begin
                  kind_dec  = RESP_R6;
                  rca_dec   = rca + `SD_RCA_STEP;
                  state_dec = CARD_STBY;
               end
            end
            `SD_CMD7_SEL_CARD: begin
               if (rca_match) begin
                  if (card_state == CARD_STBY) begin
                     kind_dec  = RESP_R1B;
                     state_dec = CARD_TRAN;
                  end
               end else begin
                  // deselect is silent
                  kind_dec  = RESP_NONE;
                  desel_dec = 1'b1;
                  if (card_state == CARD_TRAN) begin
                     state_dec = CARD_STBY;
                  end
               end
            end
            `SD_CMD8_SEND_IF_COND: begin
               if (card_state == CARD_IDLE) begin
                  kind_dec = (op.arg[11:8] == 4'b0001) ? RESP_R7 : RESP_NONE;
               end
            end
            `SD_CMD13_SEND_STATUS: begin
               if (!rca_match) begin
                  kind_dec = RESP_NONE;
               end else if (card_state == CARD_STBY || card_state == CARD_TRAN) begin
                  kind_dec = RESP_R1;
               end
            end
            `SD_CMD15_GO_INACTIVE: begin
               kind_dec = RESP_NONE;
               if (rca_match && (card_state == CARD_STBY || card_state == CARD_TRAN)) begin
                  state_dec = CARD_INA;
               end
            end
            `SD_CMD55_APP_CMD: begin
               if (!rca_match) begin
                  kind_dec = RESP_NONE;
               end else if (card_state == CARD_IDLE || card_state == CARD_STBY ||
                            card_state == CARD_TRAN) begin
                  kind_dec = RESP_R1;
                  app_dec  = 1'b1;
               end
            end
            // CMD1 and CMD5 come from SPI and SDIO probing and are not flagged
            default: unhandled_dec = (op.index != 6'd1) && (op.index != 6'd5);
         endcase
      end

      status_dec = status;
      status_dec[`SD_STAT_COM_CRC_ERROR]   = 1'b0;
      status_dec[`SD_STAT_ILLEGAL_COMMAND] = 1'b0;
      status_dec[`SD_STAT_STATE_LSB +: 4]  = card_state;
      if (app_dec) begin
         status_dec[`SD_STAT_APP_CMD] = 1'b1;
      end

      case (kind_dec)
         RESP_R3: payload_dec = ocr_dec;
         // new rca plus the compressed status
         RESP_R6: payload_dec = {rca_dec, status_dec[23:22], status_dec[19], status_dec[12:0]};
         RESP_R7: payload_dec = {20'h0, 4'b0001, op.arg[7:0]};
         default: payload_dec = '0;
      endcase
   end

   always_ff @(posedge clk_50) begin
      if (!reset_s) begin
         card_state        <= CARD_IDLE;
         state_next        <= CARD_IDLE;
         rca               <= '0;
         ocr               <= OCR_RESET;
         status            <= STATUS_RESET;
         app_pending       <= 1'b0;
         busy              <= 1'b0;
         req_valid         <= 1'b0;
         err_cmd_crc       <= 1'b0;
         err_unhandled_cmd <= 1'b0;
         info_card_desel   <= 1'b0;
      end else begin
         req_valid <= 1'b0;
         if (crc_fail) begin
            err_cmd_crc <= 1'b1;
            status[`SD_STAT_COM_CRC_ERROR] <= 1'b1;
         end
         if (op_valid) begin
            status      <= status_dec;
            rca         <= rca_dec;
            ocr         <= ocr_dec;
            app_pending <= app_dec;
            state_next  <= state_dec;
            if (unhandled_dec) begin
               err_unhandled_cmd <= 1'b1;
            end
            if (desel_dec) begin
               info_card_desel <= 1'b1;
            end
            if (kind_dec == RESP_NONE || kind_dec == RESP_BAD) begin
               // nothing to send, finish now
               card_state <= state_dec;
               busy       <= 1'b0;
            end else begin
               busy      <= 1'b1;
               req_valid <= 1'b1;
            end
            if (kind_dec == RESP_BAD) begin
               status[`SD_STAT_ILLEGAL_COMMAND] <= 1'b1;
            end
            if (reset_dec) begin
               card_state        <= CARD_IDLE;
               rca               <= '0;
               ocr               <= OCR_RESET;
               status            <= STATUS_RESET;
               app_pending       <= 1'b0;
               err_cmd_crc       <= 1'b0;
               err_unhandled_cmd <= 1'b0;
               info_card_desel   <= 1'b0;
            end
         end
         if (sent) begin
            card_state <= state_next;
            busy       <= 1'b0;
            // app flag ends with the ACMD response
            if (last_app) begin
               app_pending <= 1'b0;
               status[`SD_STAT_APP_CMD] <= 1'b0;
            end
            if (req.index == `SD_CMD13_SEND_STATUS) begin
               status <= status & ~`SD_STAT_CLEAR_ON_READ;
            end
         end
      end
   end

   always_ff @(posedge clk_50) begin
      if (op_valid) begin
         req      <= '{kind: kind_dec, index: op.index, status: status_dec, payload: payload_dec};
         last_app <= op.app;
      end
   end

endmodule

`default_nettype wire

// ==== design/sd_cmd_decode.sv ====
// Inputs must already be synchronous to clk_50. Only ACMD41 is decoded as an application command.
`default_nettype none
`include "sd_link_params.svh"

module sd_cmd_decode (
   input  wire                       clk_50,
   input  wire                       reset_s,
   input  wire [47:0]                cmd_in,
   input  wire                       cmd_crc_good,
   input  wire                       cmd_act,
   input  wire                       busy,
   input  wire                       app_pending,
   output logic                      op_valid,
   output sd_link_pkg::cmd_op_t      op,
   output logic                      crc_fail,
   output sd_link_pkg::cmd_index_t   cmd_last
);
   import sd_link_pkg::*;

   cmd_index_t frame_index;
   cmd_arg_t   frame_arg;
   logic       frame_app;
   logic       cmd_act_q;
   logic       accept;

   // start, direction, index, argument, crc7, end
   assign frame_index = cmd_in[45:40];
   assign frame_arg   = cmd_in[39:8];

   // rising edge only, an edge during busy is lost
   assign accept = cmd_act & ~cmd_act_q & ~busy;

   // any other index after CMD55 is retried as a plain command
   assign frame_app = app_pending && (frame_index == `SD_ACMD41_SEND_OP_COND);

   always_ff @(posedge clk_50) begin
      if (!reset_s) begin
         cmd_act_q <= 1'b0;
         op_valid  <= 1'b0;
         crc_fail  <= 1'b0;
         cmd_last  <= '0;
      end else begin
         cmd_act_q <= cmd_act;
         op_valid  <= accept & cmd_crc_good;
         crc_fail  <= accept & ~cmd_crc_good;
         if (accept && cmd_crc_good) begin
            cmd_last <= frame_index;
         end
      end
   end

   // command payload, only meaningful alongside op_valid
   always_ff @(posedge clk_50) begin
      if (accept && cmd_crc_good) begin
         op <= '{index: frame_index, arg: frame_arg, app: frame_app};
      end
   end

endmodule

`default_nettype wire

// ==== design/sd_link_pkg.sv ====
// The ina state has no status field code in the SD spec and takes the first reserved value 9.
`default_nettype none

package sd_link_pkg;

   typedef logic [5:0]   cmd_index_t;
   typedef logic [31:0]  cmd_arg_t;
   typedef logic [15:0]  rca_t;
   typedef logic [31:0]  ocr_t;
   typedef logic [31:0]  card_status_t;
   typedef logic [31:0]  resp_payload_t;
   typedef logic [135:0] resp_frame_t;

   // encodings match status bits 12..9
   typedef enum logic [3:0] {
      CARD_IDLE  = 4'd0,
      CARD_READY = 4'd1,
      CARD_IDENT = 4'd2,
      CARD_STBY  = 4'd3,
      CARD_TRAN  = 4'd4,
      CARD_DATA  = 4'd5,
      CARD_RCV   = 4'd6,
      CARD_PRG   = 4'd7,
      CARD_DIS   = 4'd8,
      CARD_INA   = 4'd9
   } card_state_e;

   // value seen by the phy on resp_type
   typedef enum logic [3:0] {
      RESP_NONE = 4'd0,
      RESP_BAD  = 4'd1,
      RESP_R1   = 4'd2,
      RESP_R1B  = 4'd3,
      RESP_R2   = 4'd4,
      RESP_R3   = 4'd5,
      RESP_R6   = 4'd6,
      RESP_R7   = 4'd7
   } resp_kind_e;

   // decoded command, decode to execute
   typedef struct packed {
      cmd_index_t index;
      cmd_arg_t   arg;
      logic       app;
   } cmd_op_t;

   // response request, execute to format
   // payload is the ocr, the r6 field or the r7 echo
   typedef struct packed {
      resp_kind_e    kind;
      cmd_index_t    index;
      card_status_t  status;
      resp_payload_t payload;
   } resp_req_t;

endpackage

`default_nettype wire

// ==== include/sd_link_params.svh ====
// Constants model one fixed high-capacity 3.3 V card. The CID fields are placeholders.
`ifndef SD_LINK_PARAMS_SVH
`define SD_LINK_PARAMS_SVH

// kept command indices
`define SD_CMD0_GO_IDLE          6'd0
`define SD_CMD2_ALL_SEND_CID     6'd2
`define SD_CMD3_SEND_REL_ADDR    6'd3
`define SD_CMD7_SEL_CARD         6'd7
`define SD_CMD8_SEND_IF_COND     6'd8
`define SD_CMD13_SEND_STATUS     6'd13
`define SD_CMD15_GO_INACTIVE     6'd15
`define SD_CMD55_APP_CMD         6'd55
`define SD_ACMD41_SEND_OP_COND   6'd41

// relative address advance on every CMD3
`define SD_RCA_STEP              16'h1337

// ocr bits 23..15 set, 2.7 V to 3.6 V
`define SD_VOLTAGE_WINDOW        24'hFF8000
`define SD_OCR_POWERED_UP        31

// mid, oid, pnm, prv, psn, mdt and a crc byte of FF
`define SD_CID                   128'h0253_4453_444c_4e4b_1000_0013_3701_31FF

// card status word bit positions
`define SD_STAT_COM_CRC_ERROR    23
`define SD_STAT_ILLEGAL_COMMAND  22
`define SD_STAT_STATE_LSB        9
`define SD_STAT_READY_FOR_DATA   8
`define SD_STAT_APP_CMD          5
// bits cleared once a CMD13 response has gone out
`define SD_STAT_CLEAR_ON_READ    32'hFD31A028

`endif
